/* tb.f */
+incdir+verilog
+incdir+bench
verilog/usb_pid_pkg.sv
verilog/usb_wb_pkg.sv
verilog/usb_rx_packet_fsm.sv
verilog/usb_crc5_check.sv
verilog/usb_crc16_accum.sv
verilog/usb_rx_stat_regs.sv
verilog/usb_rx_top.sv
bench/usb_rx_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the receive path testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module usb_rx_tb -f tb.f > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vusb_rx_tb > sim.log 2>&1 || echo "Simulator returned an error status" >> sim.log
cat sim.log

grep -q -- ">>> FAIL" sim.log && exit 1
grep -q -- ">>> PASS" sim.log || exit 1
exit 0

/* bench/usb_rx_tasks.svh */
`ifndef USB_RX_TASKS_SVH
`define USB_RX_TASKS_SVH

// USB CRC5, sent complemented with the register MSB first on the wire
function automatic logic [4:0] crc5_field(input logic [10:0] bits);
  logic [4:0] crc;
  logic [4:0] field;
  crc = 5'h1F;
  for (int i = 0; i < 11; i++) begin
    if (crc[4] ^ bits[i]) begin
      crc = {crc[3:0], 1'b0} ^ 5'h05;
    end else begin
      crc = {crc[3:0], 1'b0};
    end
  end
  for (int i = 0; i < 5; i++) begin
    field[i] = ~crc[4-i];
  end
  return field;
endfunction

// One byte of USB CRC16, bit 0 first
function automatic logic [15:0] crc16_step(input logic [15:0] crc_in, input logic [7:0] b);
  logic [15:0] crc;
  crc = crc_in;
  for (int i = 0; i < 8; i++) begin
    if (crc[15] ^ b[i]) begin
      crc = {crc[14:0], 1'b0} ^ 16'h8005;
    end else begin
      crc = {crc[14:0], 1'b0};
    end
  end
  return crc;
endfunction

// Called at 10 ns after an edge, returns the index of the edge that takes the beat
task automatic drive_beat(input logic [7:0] b, input logic last, output int edge_idx);
  edge_idx = cycle + 1;
  rx_valid = 1'b1;
  rx_data  = b;
  rx_last  = last;
  @(posedge clock);
  #10;
  rx_valid = 1'b0;
  rx_last  = 1'b0;
  rx_data  = 8'h00;
endtask

task automatic idle_cycles(input int n);
  repeat (n) @(posedge clock);
  #10;
endtask

// Error flag is a level, the counter sees only its rising edge
task automatic note_crc_result(input int last_edge, input logic bad);
  err_upd[last_edge+1] = 1'b1;
  err_val[last_edge+1] = bad;
  if (bad && !err_level) begin
    err_cnt++;
  end
  err_level = bad;
endtask

task automatic send_sof(input logic [10:0] fnum, input logic corrupt);
  logic [4:0] field;
  int e;
  field = crc5_field(fnum) ^ {4'b0000, corrupt};
  drive_beat({~4'b0101, 4'b0101}, 1'b0, e);
  drive_beat(fnum[7:0], 1'b0, e);
  drive_beat({field, fnum[10:8]}, 1'b1, e);
  if (!corrupt) begin
    exp_sof[e+1]   = 1'b1;
    exp_frame[e+1] = fnum;
    sof_cnt++;
    last_frame = fnum;
  end
  note_crc_result(e, corrupt);
  idle_cycles(4);
endtask

task automatic send_token(input usb_pid_pkg::pid_e pid, input logic [6:0] addr,
                          input logic [3:0] endp, input logic corrupt);
  logic [10:0] bits;
  logic [4:0]  field;
  int e;
  bits  = {endp, addr};
  field = crc5_field(bits) ^ {corrupt, 4'b0000};
  drive_beat({~pid, pid}, 1'b0, e);
  drive_beat(bits[7:0], 1'b0, e);
  drive_beat({field, bits[10:8]}, 1'b1, e);
  if (!corrupt) begin
    exp_tok[e+1]         = 1'b1;
    exp_token[e+1].ttype = pid[3:2];
    exp_token[e+1].addr  = addr;
    exp_token[e+1].endp  = endp;
    tok_cnt++;
    last_token = exp_token[e+1];
  end
  note_crc_result(e, corrupt);
  idle_cycles(4);
endtask

task automatic send_data(input usb_pid_pkg::pid_e pid, input int len, input logic corrupt);
  logic [7:0]  beats [0:17];
  logic [15:0] crc;
  int e;
  crc = 16'hFFFF;
  for (int k = 0; k < len; k++) begin
    beats[k] = 8'($random(seed));
    crc = crc16_step(crc, beats[k]);
  end
  // Complemented CRC16 with its MSB on the wire first
  for (int j = 0; j < 8; j++) begin
    beats[len][j]   = ~crc[15-j];
    beats[len+1][j] = ~crc[7-j];
  end
  beats[len+1][4] = beats[len+1][4] ^ corrupt;
  drive_beat({~pid, pid}, 1'b0, e);
  for (int j = 0; j < len + 2; j++) begin
    drive_beat(beats[j], (j == len + 1), e);
    // Payload byte j-2 leaves with the beat that carries byte j
    if (j >= 2) begin
      exp_dv[e]         = 1'b1;
      exp_data[e].data  = beats[j-2];
      exp_data[e].last  = (j == len + 1);
      exp_data[e].dtype = pid[3:2];
    end
  end
  if (!corrupt) begin
    data_cnt++;
  end
  note_crc_result(e, corrupt);
  idle_cycles(4);
endtask

task automatic send_handshake(input usb_pid_pkg::pid_e pid);
  int e;
  drive_beat({~pid, pid}, 1'b1, e);
  exp_hsk[e]      = 1'b1;
  exp_hsk_type[e] = pid[3:2];
  idle_cycles(4);
endtask

// Both nibbles equal, so the check nibble never matches
task automatic send_bad_pid(input usb_pid_pkg::pid_e pid);
  int e;
  drive_beat({pid, pid}, 1'b1, e);
  idle_cycles(4);
endtask

task automatic wb_read(input usb_wb_pkg::stat_addr_e addr, output logic [31:0] rdata);
  wb_req.cyc = 1'b1;
  wb_req.stb = 1'b1;
  wb_req.we  = 1'b0;
  wb_req.adr = addr;
  wb_req.dat = 32'h0;
  do begin
    @(posedge clock);
    #10;
  end while (wb_rsp.ack !== 1'b1);
  rdata  = wb_rsp.dat;
  wb_req = '0;
  @(posedge clock);
  #10;
  assert (wb_rsp.ack === 1'b0) else fail_value("wb_o.ack", 32'h0, 32'(wb_rsp.ack));
endtask

task automatic wb_write(input usb_wb_pkg::stat_addr_e addr, input logic [31:0] wdata);
  wb_req.cyc = 1'b1;
  wb_req.stb = 1'b1;
  wb_req.we  = 1'b1;
  wb_req.adr = addr;
  wb_req.dat = wdata;
  do begin
    @(posedge clock);
    #10;
  end while (wb_rsp.ack !== 1'b1);
  wb_req = '0;
  @(posedge clock);
  #10;
endtask

task automatic check_reg(input usb_wb_pkg::stat_addr_e addr, input string name,
                         input logic [31:0] expected);
  logic [31:0] got;
  wb_read(addr, got);
  assert (got === expected) else fail_value(name, expected, got);
endtask

`endif

/* bench/usb_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "usb_rx_settings.svh"

module usb_rx_tb;

  localparam int NUM_PKTS    = 18;
  localparam int TIMEOUT_CYC = NUM_PKTS * 40 + 200;
  localparam int MAX_CYC     = 4096;
  localparam int CNT_W       = `USB_STAT_CNT_W;

  logic                  clock;
  logic                  reset;
  logic                  rx_valid;
  logic                  rx_last;
  logic [7:0]            rx_data;
  logic                  rx_ready;
  logic                  data_valid;
  usb_pid_pkg::payload_s data;
  logic                  sof;
  logic [10:0]           frame;
  usb_pid_pkg::token_s   token;
  logic                  token_valid;
  logic                  hsk;
  logic [1:0]            hsk_type;
  logic                  crc_err;
  usb_wb_pkg::wb_req_s   wb_req;
  usb_wb_pkg::wb_rsp_s   wb_rsp;

  int     cycle = 0;
  int     error_count = 0;
  integer seed;
  logic   checking;
  logic   err_exp;

  // Expected outputs indexed by the edge after which they are visible
  logic                  exp_sof [MAX_CYC];
  logic [10:0]           exp_frame [MAX_CYC];
  logic                  exp_tok [MAX_CYC];
  usb_pid_pkg::token_s   exp_token [MAX_CYC];
  logic                  exp_hsk [MAX_CYC];
  logic [1:0]            exp_hsk_type [MAX_CYC];
  logic                  exp_dv [MAX_CYC];
  usb_pid_pkg::payload_s exp_data [MAX_CYC];
  logic                  err_upd [MAX_CYC];
  logic                  err_val [MAX_CYC];

  // Status register model
  logic [CNT_W-1:0]    sof_cnt;
  logic [CNT_W-1:0]    tok_cnt;
  logic [CNT_W-1:0]    data_cnt;
  logic [CNT_W-1:0]    err_cnt;
  logic                err_level;
  usb_pid_pkg::token_s last_token;
  logic [10:0]         last_frame;

  usb_rx_top dut (
    .clock         (clock),
    .reset         (reset),
    .rx_valid_i    (rx_valid),
    .rx_last_i     (rx_last),
    .rx_data_i     (rx_data),
    .rx_ready_o    (rx_ready),
    .data_valid_o  (data_valid),
    .data_o        (data),
    .sof_o         (sof),
    .frame_o       (frame),
    .token_o       (token),
    .token_valid_o (token_valid),
    .hsk_o         (hsk),
    .hsk_type_o    (hsk_type),
    .crc_err_o     (crc_err),
    .wb_i          (wb_req),
    .wb_o          (wb_rsp)
  );

  task automatic fail_value(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    error_count++;
    $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
    $display(">>> FAIL");
    $fatal(1, "Stopped at first mismatch");
  endtask

  `include "usb_rx_tasks.svh"

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  // Outputs sampled in mid cycle away from the edges
  always @(negedge clock) begin
    if (checking && cycle < MAX_CYC) begin
      if (err_upd[cycle]) begin
        err_exp = err_val[cycle];
      end
      assert (rx_ready === 1'b1) else fail_value("rx_ready_o", 32'h1, 32'(rx_ready));
      assert (sof === exp_sof[cycle]) else fail_value("sof_o", 32'(exp_sof[cycle]), 32'(sof));
      if (exp_sof[cycle]) begin
        assert (frame === exp_frame[cycle])
          else fail_value("frame_o", 32'(exp_frame[cycle]), 32'(frame));
      end
      assert (token_valid === exp_tok[cycle])
        else fail_value("token_valid_o", 32'(exp_tok[cycle]), 32'(token_valid));
      if (exp_tok[cycle]) begin
        assert (token === exp_token[cycle])
          else fail_value("token_o", 32'(exp_token[cycle]), 32'(token));
      end
      assert (hsk === exp_hsk[cycle]) else fail_value("hsk_o", 32'(exp_hsk[cycle]), 32'(hsk));
      if (exp_hsk[cycle]) begin
        assert (hsk_type === exp_hsk_type[cycle])
          else fail_value("hsk_type_o", 32'(exp_hsk_type[cycle]), 32'(hsk_type));
      end
      assert (data_valid === exp_dv[cycle])
        else fail_value("data_valid_o", 32'(exp_dv[cycle]), 32'(data_valid));
      if (exp_dv[cycle]) begin
        assert (data === exp_data[cycle])
          else fail_value("data_o", 32'(exp_data[cycle]), 32'(data));
      end
      assert (crc_err === err_exp) else fail_value("crc_err_o", 32'(err_exp), 32'(crc_err));
    end
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clock);
    $display("Timeout: the packet sequence did not finish in time");
    $display(">>> FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    for (int i = 0; i < MAX_CYC; i++) begin
      exp_sof[i]      = 1'b0;
      exp_tok[i]      = 1'b0;
      exp_hsk[i]      = 1'b0;
      exp_dv[i]       = 1'b0;
      err_upd[i]      = 1'b0;
      exp_frame[i]    = '0;
      exp_token[i]    = '0;
      exp_hsk_type[i] = '0;
      exp_data[i]     = '0;
      err_val[i]      = 1'b0;
    end
    seed       = 82;
    checking   = 1'b0;
    err_exp    = 1'b0;
    err_level  = 1'b0;
    sof_cnt    = '0;
    tok_cnt    = '0;
    data_cnt   = '0;
    err_cnt    = '0;
    last_token = '0;
    last_frame = '0;
    rx_valid   = 1'b0;
    rx_last    = 1'b0;
    rx_data    = 8'h00;
    wb_req     = '0;
    reset      = 1'b1;
    repeat (4) @(posedge clock);
    #10;
    reset    = 1'b0;
    checking = 1'b1;
    idle_cycles(2);

    // Frame start packets and a PID with a broken check nibble
    send_sof(11'h123, 1'b0);
    send_sof(11'h7FF, 1'b0);
    send_bad_pid(usb_pid_pkg::PID_ACK);

    // Two CRC errors in a row raise the error flag only once
    send_sof(11'h055, 1'b1);
    send_token(usb_pid_pkg::PID_IN, 7'h11, 4'h3, 1'b1);

    send_token(usb_pid_pkg::PID_OUT, 7'h05, 4'h1, 1'b0);
    send_token(usb_pid_pkg::PID_IN, 7'h7F, 4'hF, 1'b0);
    send_token(usb_pid_pkg::PID_SETUP, 7'h2A, 4'h0, 1'b0);
    send_token(usb_pid_pkg::PID_SETUP, 7'h40, 4'h8, 1'b0);

    // Payload lengths from 1 to 16 bytes
    send_data(usb_pid_pkg::PID_DATA0, 1 + int'($unsigned($random(seed)) % 16), 1'b0);
    send_data(usb_pid_pkg::PID_DATA1, 1 + int'($unsigned($random(seed)) % 16), 1'b0);
    send_data(usb_pid_pkg::PID_DATA0, 1, 1'b0);
    send_data(usb_pid_pkg::PID_DATA1, 1 + int'($unsigned($random(seed)) % 16), 1'b1);
    send_data(usb_pid_pkg::PID_DATA0, 16, 1'b0);

    send_handshake(usb_pid_pkg::PID_ACK);
    send_handshake(usb_pid_pkg::PID_NAK);
    send_handshake(usb_pid_pkg::PID_STALL);
    send_handshake(usb_pid_pkg::PID_NYET);

    check_reg(usb_wb_pkg::STAT_SOF_CNT, "SOF_CNT", 32'(sof_cnt));
    check_reg(usb_wb_pkg::STAT_TOK_CNT, "TOK_CNT", 32'(tok_cnt));
    check_reg(usb_wb_pkg::STAT_DATA_CNT, "DATA_CNT", 32'(data_cnt));
    check_reg(usb_wb_pkg::STAT_ERR_CNT, "ERR_CNT", 32'(err_cnt));
    check_reg(usb_wb_pkg::STAT_LAST_TOKEN, "LAST_TOKEN", 32'(last_token));
    check_reg(usb_wb_pkg::STAT_FRAME_NUM, "FRAME_NUM", 32'(last_frame));

    // Counter clear through the control register
    wb_write(usb_wb_pkg::STAT_CTRL, 32'h1);
    check_reg(usb_wb_pkg::STAT_SOF_CNT, "SOF_CNT", 32'h0);
    check_reg(usb_wb_pkg::STAT_TOK_CNT, "TOK_CNT", 32'h0);
    check_reg(usb_wb_pkg::STAT_DATA_CNT, "DATA_CNT", 32'h0);
    check_reg(usb_wb_pkg::STAT_ERR_CNT, "ERR_CNT", 32'h0);

    idle_cycles(4);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/usb_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_rx_top (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   rx_valid_i,
  input  wire                   rx_last_i,
  input  wire  [7:0]            rx_data_i,
  output logic                  rx_ready_o,
  output logic                  data_valid_o,
  output usb_pid_pkg::payload_s data_o,
  output logic                  sof_o,
  output logic [10:0]           frame_o,
  output usb_pid_pkg::token_s   token_o,
  output logic                  token_valid_o,
  output logic                  hsk_o,
  output logic [1:0]            hsk_type_o,
  output logic                  crc_err_o,
  input  wire  usb_wb_pkg::wb_req_s wb_i,
  output usb_wb_pkg::wb_rsp_s   wb_o
);

  logic [10:0] tok_bits;
  logic [4:0]  tok_crc;
  logic        crc5_match;
  logic        crc_clear;
  logic [7:0]  crc_byte;
  logic        crc_en;
  logic        crc16_ok;
  logic        data_done;

  // No back-pressure toward the PHY
  assign rx_ready_o = 1'b1;

  usb_rx_packet_fsm u_fsm (
    .clock         (clock),
    .reset         (reset),
    .rx_valid_i    (rx_valid_i),
    .rx_last_i     (rx_last_i),
    .rx_data_i     (rx_data_i),
    .crc5_match_i  (crc5_match),
    .crc16_ok_i    (crc16_ok),
    .tok_bits_o    (tok_bits),
    .tok_crc_o     (tok_crc),
    .crc_clear_o   (crc_clear),
    .crc_byte_o    (crc_byte),
    .crc_en_o      (crc_en),
    .sof_o         (sof_o),
    .frame_o       (frame_o),
    .token_o       (token_o),
    .token_valid_o (token_valid_o),
    .hsk_o         (hsk_o),
    .hsk_type_o    (hsk_type_o),
    .data_valid_o  (data_valid_o),
    .data_o        (data_o),
    .data_done_o   (data_done),
    .crc_err_o     (crc_err_o)
  );

  usb_crc5_check u_crc5 (
    .tok_bits_i (tok_bits),
    .tok_crc_i  (tok_crc),
    .match_o    (crc5_match)
  );

  usb_crc16_accum u_crc16 (
    .clock   (clock),
    .reset   (reset),
    .clear_i (crc_clear),
    .byte_i  (crc_byte),
    .en_i    (crc_en),
    .ok_o    (crc16_ok)
  );

  usb_rx_stat_regs u_stat (
    .clock        (clock),
    .reset        (reset),
    .sof_i        (sof_o),
    .frame_i      (frame_o),
    .token_i      (token_valid_o),
    .token_type_i (token_o),
    .data_done_i  (data_done),
    .crc_err_i    (crc_err_o),
    .wb_i         (wb_i),
    .wb_o         (wb_o)
  );

endmodule

`default_nettype wire

/* verilog/usb_rx_stat_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "usb_rx_settings.svh"

module usb_rx_stat_regs (
  input  wire                 clock,
  input  wire                 reset,
  input  wire                 sof_i,
  input  wire  [10:0]         frame_i,
  input  wire                 token_i,
  input  wire  usb_pid_pkg::token_s token_type_i,
  input  wire                 data_done_i,
  input  wire                 crc_err_i,
  input  wire  usb_wb_pkg::wb_req_s wb_i,
  output usb_wb_pkg::wb_rsp_s wb_o
);

  localparam int CNT_W = `USB_STAT_CNT_W;
  localparam int TOK_W = $bits(usb_pid_pkg::token_s);

  usb_wb_pkg::stat_addr_e addr_w;
  usb_pid_pkg::token_s    last_token_q;

  logic [CNT_W-1:0]          sof_cnt_q;
  logic [CNT_W-1:0]          tok_cnt_q;
  logic [CNT_W-1:0]          data_cnt_q;
  logic [CNT_W-1:0]          err_cnt_q;
  logic [10:0]               frame_q;
  logic                      err_d_q;
  logic                      ack_q;
  logic                      req_w;
  logic                      clear_w;
  logic [`USB_WB_DATA_W-1:0] rdata_w;
  logic [`USB_WB_DATA_W-1:0] rdata_q;

  // Counters stop at all ones
  function automatic logic [CNT_W-1:0] cnt_next(input logic [CNT_W-1:0] cnt, input logic inc);
    if (inc && cnt != '1) begin
      cnt_next = cnt + 1'b1;
    end else begin
      cnt_next = cnt;
    end
  endfunction

  assign addr_w  = usb_wb_pkg::stat_addr_e'(wb_i.adr);
  assign req_w   = wb_i.cyc && wb_i.stb && !ack_q;
  assign clear_w = req_w && wb_i.we && (addr_w == usb_wb_pkg::STAT_CTRL) && wb_i.dat[0];

  always_ff @(posedge clock) begin
    if (reset || clear_w) begin
      sof_cnt_q  <= '0;
      tok_cnt_q  <= '0;
      data_cnt_q <= '0;
      err_cnt_q  <= '0;
    end else begin
      sof_cnt_q  <= cnt_next(sof_cnt_q, sof_i);
      tok_cnt_q  <= cnt_next(tok_cnt_q, token_i);
      data_cnt_q <= cnt_next(data_cnt_q, data_done_i);
      // Error flag is a level, count only its rising edge
      err_cnt_q  <= cnt_next(err_cnt_q, crc_err_i && !err_d_q);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      err_d_q <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      err_d_q <= crc_err_i;
      ack_q   <= wb_i.cyc && wb_i.stb;
    end
  end

  always_ff @(posedge clock) begin
    if (token_i) begin
      last_token_q <= token_type_i;
    end
    if (sof_i) begin
      frame_q <= frame_i;
    end
  end

  always_comb begin
    rdata_w = '0;
    case (addr_w)
      usb_wb_pkg::STAT_SOF_CNT:    rdata_w[CNT_W-1:0] = sof_cnt_q;
      usb_wb_pkg::STAT_TOK_CNT:    rdata_w[CNT_W-1:0] = tok_cnt_q;
      usb_wb_pkg::STAT_DATA_CNT:   rdata_w[CNT_W-1:0] = data_cnt_q;
      usb_wb_pkg::STAT_ERR_CNT:    rdata_w[CNT_W-1:0] = err_cnt_q;
      usb_wb_pkg::STAT_LAST_TOKEN: rdata_w[TOK_W-1:0] = last_token_q;
      usb_wb_pkg::STAT_FRAME_NUM:  rdata_w[10:0] = frame_q;
      default:                     rdata_w = '0;
    endcase
  end

  // Read data is captured with the request and presented with ack
  always_ff @(posedge clock) begin
    if (req_w) begin
      rdata_q <= rdata_w;
    end
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = rdata_q;

endmodule

`default_nettype wire

/* verilog/usb_crc16_accum.sv */
`timescale 1ns/1ps
`default_nettype none

`include "usb_rx_settings.svh"

module usb_crc16_accum (
  input  wire        clock,
  input  wire        reset,
  input  wire        clear_i,
  input  wire  [7:0] byte_i,
  input  wire        en_i,
  output logic       ok_o
);

  localparam logic [15:0] CRC16_POLY = 16'h8005;

  logic [15:0] crc_q;
  logic [15:0] crc_next_w;

  // One byte per step, least significant bit first as on the bus
  always_comb begin
    crc_next_w = crc_q;
    for (int i = 0; i < 8; i++) begin
      if (crc_next_w[15] ^ byte_i[i]) begin
        crc_next_w = {crc_next_w[14:0], 1'b0} ^ CRC16_POLY;
      end else begin
        crc_next_w = {crc_next_w[14:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset || clear_i) begin
      crc_q <= `USB_CRC16_SEED;
    end else if (en_i) begin
      crc_q <= crc_next_w;
    end
  end

  // Residue check includes the byte currently on byte_i
  assign ok_o = (crc_next_w == `USB_CRC16_RESIDUE);

endmodule

`default_nettype wire

/* verilog/usb_crc5_check.sv */
`timescale 1ns/1ps
`default_nettype none

`include "usb_rx_settings.svh"

module usb_crc5_check (
  input  wire  [10:0] tok_bits_i,
  input  wire  [4:0]  tok_crc_i,
  output logic        match_o
);

  localparam logic [4:0] CRC5_POLY = 5'h05;

  logic [15:0] stream_w;
  logic [4:0]  crc_w;

  // Bit 0 goes on the wire first, the CRC field follows the 11 data bits
  assign stream_w = {tok_crc_i, tok_bits_i};

  // Running through the received field equals comparing it with the
  // complemented, bit-reversed CRC of the data bits
  always_comb begin
    crc_w = `USB_CRC5_SEED;
    for (int i = 0; i < 16; i++) begin
      if (crc_w[4] ^ stream_w[i]) begin
        crc_w = {crc_w[3:0], 1'b0} ^ CRC5_POLY;
      end else begin
        crc_w = {crc_w[3:0], 1'b0};
      end
    end
  end

  assign match_o = (crc_w == `USB_CRC5_RESIDUE);

endmodule

`default_nettype wire

/* verilog/usb_rx_packet_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_rx_packet_fsm (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   rx_valid_i,
  input  wire                   rx_last_i,
  input  wire  [7:0]            rx_data_i,
  input  wire                   crc5_match_i,
  input  wire                   crc16_ok_i,
  output logic [10:0]           tok_bits_o,
  output logic [4:0]            tok_crc_o,
  output logic                  crc_clear_o,
  output logic [7:0]            crc_byte_o,
  output logic                  crc_en_o,
  output logic                  sof_o,
  output logic [10:0]           frame_o,
  output usb_pid_pkg::token_s   token_o,
  output logic                  token_valid_o,
  output logic                  hsk_o,
  output logic [1:0]            hsk_type_o,
  output logic                  data_valid_o,
  output usb_pid_pkg::payload_s data_o,
  output logic                  data_done_o,
  output logic                  crc_err_o
);

  usb_pid_pkg::rx_state_e state_q;
  usb_pid_pkg::pkt_kind_e kind_w;
  usb_pid_pkg::payload_s  data_q;

  logic [3:0]  pid_w;
  logic        pid_start_w;
  logic [1:0]  trn_type_q;
  logic [7:0]  buf0_q;
  logic [7:0]  buf1_q;
  logic        vld0_q;
  logic        vld1_q;
  logic [10:0] bits_q;
  logic [4:0]  crc5_q;
  logic        crc_en_q;
  logic        sof_q;
  logic        tok_q;
  logic        hsk_q;
  logic        done_q;
  logic        err_q;
  logic        dvalid_q;

  // PID is accepted only when the high nibble is the complement of the low one
  assign pid_w       = rx_data_i[3:0];
  assign kind_w      = usb_pid_pkg::pkt_kind_e'(pid_w[1:0]);
  assign pid_start_w = rx_valid_i && (pid_w == ~rx_data_i[7:4])
                       && (state_q == usb_pid_pkg::ST_IDLE);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= usb_pid_pkg::ST_IDLE;
    end else begin
      case (state_q)
        usb_pid_pkg::ST_IDLE: begin
          if (pid_start_w) begin
            if (usb_pid_pkg::pid_e'(pid_w) == usb_pid_pkg::PID_SOF) begin
              state_q <= usb_pid_pkg::ST_SOF;
            end else if (kind_w == usb_pid_pkg::KIND_TOKEN) begin
              state_q <= usb_pid_pkg::ST_TOKEN;
            end else if (kind_w == usb_pid_pkg::KIND_DATA) begin
              state_q <= usb_pid_pkg::ST_DATA;
            end
          end
        end
        usb_pid_pkg::ST_SOF: begin
          if (rx_valid_i && rx_last_i) begin
            state_q <= usb_pid_pkg::ST_SOF_CRC;
          end
        end
        usb_pid_pkg::ST_TOKEN: begin
          if (rx_valid_i && rx_last_i) begin
            state_q <= usb_pid_pkg::ST_TOKEN_CRC;
          end
        end
        usb_pid_pkg::ST_DATA: begin
          if (rx_valid_i && rx_last_i) begin
            state_q <= usb_pid_pkg::ST_DATA_CRC;
          end
        end
        default: state_q <= usb_pid_pkg::ST_IDLE;
      endcase
    end
  end

  // Valid tags count the first two bytes after the PID
  always_ff @(posedge clock) begin
    if (reset || state_q == usb_pid_pkg::ST_IDLE) begin
      vld0_q <= 1'b0;
      vld1_q <= 1'b0;
    end else if (rx_valid_i) begin
      vld0_q <= 1'b1;
      vld1_q <= vld0_q;
    end
  end

  // Two-byte delay line, so the CRC bytes never leave it
  always_ff @(posedge clock) begin
    if (rx_valid_i) begin
      buf0_q <= rx_data_i;
      buf1_q <= buf0_q;
    end
  end

  always_ff @(posedge clock) begin
    if (pid_start_w) begin
      trn_type_q <= pid_w[3:2];
    end
    if (rx_valid_i) begin
      data_q.data  <= buf1_q;
      data_q.last  <= rx_last_i;
      data_q.dtype <= trn_type_q;
    end
  end

  // Token and SOF fields, second byte carries bits 10:8 and the CRC5
  always_ff @(posedge clock) begin
    if (rx_valid_i && (state_q == usb_pid_pkg::ST_SOF || state_q == usb_pid_pkg::ST_TOKEN)) begin
      if (!vld0_q) begin
        bits_q[7:0] <= rx_data_i;
      end else if (!vld1_q) begin
        bits_q[10:8] <= rx_data_i[2:0];
        crc5_q       <= rx_data_i[7:3];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      crc_en_q <= 1'b0;
      dvalid_q <= 1'b0;
      sof_q    <= 1'b0;
      tok_q    <= 1'b0;
      hsk_q    <= 1'b0;
      done_q   <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      crc_en_q <= rx_valid_i && (state_q == usb_pid_pkg::ST_DATA);
      dvalid_q <= rx_valid_i && vld1_q && (state_q == usb_pid_pkg::ST_DATA);
      sof_q    <= (state_q == usb_pid_pkg::ST_SOF_CRC) && crc5_match_i;
      tok_q    <= (state_q == usb_pid_pkg::ST_TOKEN_CRC) && crc5_match_i;
      hsk_q    <= pid_start_w && (kind_w == usb_pid_pkg::KIND_HSK);
      done_q   <= (state_q == usb_pid_pkg::ST_DATA_CRC) && crc16_ok_i;
      // Error level holds until the next packet check
      if (state_q == usb_pid_pkg::ST_SOF_CRC || state_q == usb_pid_pkg::ST_TOKEN_CRC) begin
        err_q <= !crc5_match_i;
      end else if (state_q == usb_pid_pkg::ST_DATA_CRC) begin
        err_q <= !crc16_ok_i;
      end
    end
  end

  // CRC16 sees each data byte one cycle late, so the final check lands in DATA_CRC
  assign crc_clear_o = (state_q == usb_pid_pkg::ST_IDLE);
  assign crc_byte_o  = buf0_q;
  assign crc_en_o    = crc_en_q;

  assign tok_bits_o    = bits_q;
  assign tok_crc_o     = crc5_q;
  assign sof_o         = sof_q;
  assign frame_o       = bits_q;
  assign token_o.ttype = trn_type_q;
  assign token_o.addr  = bits_q[6:0];
  assign token_o.endp  = bits_q[10:7];
  assign token_valid_o = tok_q;
  assign hsk_o         = hsk_q;
  assign hsk_type_o    = trn_type_q;
  assign data_valid_o  = dvalid_q;
  assign data_o        = data_q;
  assign data_done_o   = done_q;
  assign crc_err_o     = err_q;

endmodule

`default_nettype wire

/* verilog/usb_wb_pkg.sv */
`default_nettype none

`include "usb_rx_settings.svh"

package usb_wb_pkg;

  // Wishbone classic master to slave
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`USB_WB_ADDR_W-1:0] adr;
    logic [`USB_WB_DATA_W-1:0] dat;
  } wb_req_s;

  typedef struct packed {
    logic                      ack;
    logic [`USB_WB_DATA_W-1:0] dat;
  } wb_rsp_s;

  // Status register map, word addresses
  typedef enum logic [`USB_WB_ADDR_W-1:0] {
    STAT_CTRL       = 0,
    STAT_SOF_CNT    = 1,
    STAT_TOK_CNT    = 2,
    STAT_DATA_CNT   = 3,
    STAT_ERR_CNT    = 4,
    STAT_LAST_TOKEN = 5,
    STAT_FRAME_NUM  = 6
  } stat_addr_e;

endpackage

`default_nettype wire

/* verilog/usb_pid_pkg.sv */
`default_nettype none

package usb_pid_pkg;

  // Low nibble of the PID byte, the high nibble carries its complement
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_DATA2 = 4'b0111,
    PID_MDATA = 4'b1111,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110,
    PID_NYET  = 4'b0110
  } pid_e;

  // PID bits 1:0 select the packet kind
  typedef enum logic [1:0] {
    KIND_SPECIAL = 2'b00,
    KIND_TOKEN   = 2'b01,
    KIND_HSK     = 2'b10,
    KIND_DATA    = 2'b11
  } pkt_kind_e;

  typedef enum logic [6:0] {
    ST_IDLE      = 7'h01,
    ST_SOF       = 7'h02,
    ST_SOF_CRC   = 7'h04,
    ST_TOKEN     = 7'h08,
    ST_TOKEN_CRC = 7'h10,
    ST_DATA      = 7'h20,
    ST_DATA_CRC  = 7'h40
  } rx_state_e;

  // Token type is PID bits 3:2 (OUT, IN, SETUP)
  typedef struct packed {
    logic [1:0] ttype;
    logic [6:0] addr;
    logic [3:0] endp;
  } token_s;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
    logic [1:0] dtype;
  } payload_s;

endpackage

`default_nettype wire

/* verilog/usb_rx_settings.svh */
`ifndef USB_RX_SETTINGS_SVH
`define USB_RX_SETTINGS_SVH

// CRC5 over token and SOF fields, polynomial x^5 + x^2 + 1
`define USB_CRC5_SEED 5'h1F

// Register value left after a good packet has been run through together with its CRC field
`define USB_CRC5_RESIDUE 5'h0C

// CRC16 over data payload, polynomial x^16 + x^15 + x^2 + 1
`define USB_CRC16_SEED 16'hFFFF
`define USB_CRC16_RESIDUE 16'h800D

// Width of each saturating packet counter
`define USB_STAT_CNT_W 16

// Status register bus
`define USB_WB_ADDR_W 4
`define USB_WB_DATA_W 32

`endif
